// ==== all.f ====
hw/bp_pkg.sv
hw/gshare_predictor.sv
hw/btb.sv
hw/next_pc_select.sv
hw/bp_top.sv
verif/bp_tb.sv

// ==== hw/bp_pkg.sv ====
package bp_pkg;

    // datapath width, pc and targets
    localparam int xlen = 32;

    // gshare pattern table, 1024 two-bit counters
    localparam int pht_idx_w   = 10;
    localparam int pht_entries = 1 << pht_idx_w;

    // global history xors bit for bit with the pc index, so keep it the same length
    localparam int ghr_w = pht_idx_w;

    // direct-mapped btb, 64 entries
    localparam int btb_idx_w   = 6;
    localparam int btb_entries = 1 << btb_idx_w;

    // tag is whatever is left above the index and the two zero bits
    localparam int btb_tag_w = xlen - btb_idx_w - 2;

    // counter reset value, weakly not taken
    localparam logic [1:0] ctr_init = 2'b01;

    // counter end points
    localparam logic [1:0] ctr_max = 2'b11;
    localparam logic [1:0] ctr_min = 2'b00;

    // major opcodes from ir[6:0]
    typedef enum logic [6:0] {
        op_br    = 7'b1100011, // conditional branch
        op_jal   = 7'b1101111, // direct jump
        op_jalr  = 7'b1100111, // indirect jump, target from btb
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011, // alu with immediate
        op_reg   = 7'b0110011  // alu reg-reg
    } rv32i_opcode_e;

    // lookup from fetch, present every cycle
    typedef struct packed {
        logic [xlen-1:0] pc; // fetch pc
        logic [xlen-1:0] ir; // fetched instruction word
    } fetch_req_t;

    // training from execute, fire and forget
    typedef struct packed {
        logic [xlen-1:0] pc;     // pc of the resolved instruction
        logic [xlen-1:0] target; // resolved jump target
        logic            is_branch; // conditional branch resolved
        logic            is_jump;   // jal or jalr with known target
        logic            taken;     // branch outcome
    } bp_update_t;

endpackage

// ==== hw/bp_top.sv ====
`timescale 1ns/1ns

module bp_top
import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  fetch_req_t      req,     // from fetch, every cycle
    input  bp_update_t      upd,     // from execute, no back-pressure
    output logic [xlen-1:0] next_pc  // back to fetch, same cycle
);

    logic            pred_taken;
    logic            btb_hit;
    logic [xlen-1:0] btb_target;

    // direction for conditional branches
    gshare_predictor i_gshare (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_pc  (req.pc),
        .upd        (upd),         // uses is_branch, taken, pc
        .pred_taken (pred_taken)
    );

    // jalr targets
    btb i_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_pc  (req.pc),
        .upd        (upd),         // uses is_jump, pc, target
        .hit        (btb_hit),
        .target     (btb_target)
    );

    // decode and final mux
    next_pc_select i_sel (
        .req        (req),
        .pred_taken (pred_taken),
        .btb_hit    (btb_hit),
        .btb_target (btb_target),
        .next_pc    (next_pc)
    );

endmodule

// ==== hw/btb.sv ====
`timescale 1ns/1ns

module btb
import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] lookup_pc,  // fetch pc
    input  bp_update_t      upd,        // resolved jump from execute
    output logic            hit,        // valid entry with matching tag
    output logic [xlen-1:0] target      // stored target, only meaningful on hit
);

    // payload of one entry, valid bit lives apart since it is the only thing reset
    typedef struct packed {
        logic [btb_tag_w-1:0] tag;
        logic [xlen-1:0]      target;
    } btb_entry_t;

    btb_entry_t           entries [btb_entries];
    logic [btb_entries-1:0] valid;

    logic [btb_idx_w-1:0] lookup_idx;
    logic [btb_tag_w-1:0] lookup_tag;
    logic [btb_idx_w-1:0] upd_idx;
    logic [btb_tag_w-1:0] upd_tag;
    btb_entry_t           rd_entry;
    btb_entry_t           wr_entry;

    // word aligned pc split, [7:2] index and [31:8] tag
    assign lookup_idx = lookup_pc[btb_idx_w+1:2];
    assign lookup_tag = lookup_pc[xlen-1:btb_idx_w+2];
    assign upd_idx    = upd.pc[btb_idx_w+1:2];
    assign upd_tag    = upd.pc[xlen-1:btb_idx_w+2];

    // read side
    assign rd_entry = entries[lookup_idx];
    assign hit      = valid[lookup_idx] && (rd_entry.tag == lookup_tag);
    assign target   = rd_entry.target;

    // new entry from execute
    always_comb begin
        wr_entry.tag    = upd_tag;
        wr_entry.target = upd.target;
    end

    // valid bits, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (upd.is_jump) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    // tag and target store, no reset needed
    always_ff @(posedge clk) begin
        if (upd.is_jump) begin
            entries[upd_idx] <= wr_entry;  // direct mapped, just overwrite whatever was there
        end
    end

    // an alias at the same index kicks the old jump out, the next lookup of it misses
    // lookups in the update cycle still read the old entry

endmodule

// ==== hw/gshare_predictor.sv ====
`timescale 1ns/1ns

module gshare_predictor
import bp_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] lookup_pc,  // fetch pc
    input  bp_update_t      upd,        // resolved branch from execute
    output logic            pred_taken  // direction guess for lookup_pc
);

    // pattern table of 2-bit saturating counters
    logic [1:0] pht [pht_entries];

    // global history, newest outcome in bit 0
    logic [ghr_w-1:0] ghr;

    logic [pht_idx_w-1:0] lookup_idx;
    logic [pht_idx_w-1:0] upd_idx;
    logic [1:0]           lookup_ctr;
    logic [1:0]           upd_ctr;
    logic [1:0]           upd_ctr_next;

    // pc word bits hashed with history, same hash on both ports
    assign lookup_idx = lookup_pc[pht_idx_w+1:2] ^ ghr;
    assign upd_idx    = upd.pc[pht_idx_w+1:2] ^ ghr;   // history before this update

    assign lookup_ctr = pht[lookup_idx];
    assign pred_taken = lookup_ctr[1];  // msb set means taken

    assign upd_ctr = pht[upd_idx];

    // step toward the outcome, stop at the ends
    always_comb begin
        upd_ctr_next = upd_ctr;
        if (upd.taken) begin
            if (upd_ctr != ctr_max) begin
                upd_ctr_next = upd_ctr + 2'd1;
            end
        end else begin
            if (upd_ctr != ctr_min) begin
                upd_ctr_next = upd_ctr - 2'd1;
            end
        end
    end

    // counters and history move together on a branch update
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < pht_entries; i++) begin
                pht[i] <= ctr_init;  // everything weakly not taken
            end
            ghr <= '0;
        end else if (upd.is_branch) begin
            pht[upd_idx] <= upd_ctr_next;
            ghr          <= {ghr[ghr_w-2:0], upd.taken}; // shift outcome in at the bottom
        end
    end

    // jumps leave the direction state alone, is_jump is a btb concern

endmodule

// ==== hw/next_pc_select.sv ====
`timescale 1ns/1ns

module next_pc_select
import bp_pkg::*;
(
    input  fetch_req_t      req,         // fetch pc and instruction
    input  logic            pred_taken,  // gshare direction
    input  logic            btb_hit,     // btb has a target for this pc
    input  logic [xlen-1:0] btb_target,  // jalr target from btb
    output logic [xlen-1:0] next_pc      // pc to fetch next
);

    rv32i_opcode_e   opcode;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] j_imm;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] jal_target;

    // decode straight from the instruction word
    assign opcode = rv32i_opcode_e'(req.ir[6:0]);

    // b-type, 13 bit offset with implied zero lsb
    assign b_imm = {{20{req.ir[31]}}, req.ir[7], req.ir[30:25], req.ir[11:8], 1'b0};

    // j-type, 21 bit offset with implied zero lsb
    assign j_imm = {{12{req.ir[31]}}, req.ir[19:12], req.ir[20], req.ir[30:21], 1'b0};

    assign pc_plus4   = req.pc + 32'd4;      // fall through
    assign br_target  = req.pc + b_imm;      // taken branch
    assign jal_target = req.pc + j_imm;      // always taken

    // pick the next fetch pc
    always_comb begin
        case (opcode)
            op_br: begin
                if (pred_taken) begin
                    next_pc = br_target;
                end else begin
                    next_pc = pc_plus4;
                end
            end
            op_jal: begin
                next_pc = jal_target;  // no training needed, target is in the word
            end
            op_jalr: begin
                // register target unknown at fetch, trust the btb only on a hit
                if (btb_hit) begin
                    next_pc = btb_target;
                end else begin
                    next_pc = pc_plus4;
                end
            end
            default: begin
                next_pc = pc_plus4;  // lui, auipc, loads, stores, alu and anything unknown
            end
        endcase
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the next-pc predictor testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module bp_tb -f all.f -o bp_sim

./obj_dir/bp_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi

echo "simulation done, see sim.log"

// ==== verif/bp_tb.sv ====
`timescale 1ns/1ns

module bp_tb
import bp_pkg::*;
();

    logic            clk;
    logic            rst_n;
    fetch_req_t      req;
    bp_update_t      upd;
    logic [xlen-1:0] next_pc;

    // update flags in a row are {is_branch, is_jump, taken}
    typedef struct packed {
        logic [2:0]      beh;     // behavior this row belongs to
        logic            rst;     // reset pulse before the row
        fetch_req_t      req;
        bp_update_t      upd;
        logic [xlen-1:0] exp_pc;  // hand-computed next pc
    } row_t;

    row_t       rows [$];
    logic [2:0] cur_beh;
    int         seed = 32'hef5f_5ae2;
    int         checks;
    int         fails;
    int         beh_checks [7];
    int         beh_fails  [7];

    // reference model of counters, history and btb
    logic [1:0]           m_pht    [pht_entries];
    logic [ghr_w-1:0]     m_ghr;
    logic                 m_valid  [btb_entries];
    logic [btb_tag_w-1:0] m_tag    [btb_entries];
    logic [xlen-1:0]      m_target [btb_entries];

    bp_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .upd     (upd),
        .next_pc (next_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic string beh_name(input int b);
        case (b)
            1:       return "state after reset";
            2:       return "jal targets";
            3:       return "direction training";
            4:       return "btb fill and aliasing";
            5:       return "same-cycle order and reset";
            default: return "random mix against model";
        endcase
    endfunction

    task automatic model_reset();
        for (int i = 0; i < pht_entries; i++) begin
            m_pht[i] = 2'b01;  // weakly not taken
        end
        for (int i = 0; i < btb_entries; i++) begin
            m_valid[i] = 1'b0;
        end
        m_ghr = '0;
    endtask

    // next pc straight from the rv32i encoding and the model tables
    function automatic logic [xlen-1:0] model_next_pc(input fetch_req_t r);
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [9:0]  pi;
        logic [5:0]  bi;
        logic [31:0] seq;
        imm_b = {{19{r.ir[31]}}, r.ir[31], r.ir[7], r.ir[30:25], r.ir[11:8], 1'b0};
        imm_j = {{11{r.ir[31]}}, r.ir[31], r.ir[19:12], r.ir[20], r.ir[30:21], 1'b0};
        pi    = r.pc[11:2] ^ m_ghr;
        bi    = r.pc[7:2];
        seq   = r.pc + 32'd4;
        case (r.ir[6:0])
            7'b1100011: return m_pht[pi][1] ? r.pc + imm_b : seq;  // branch
            7'b1101111: return r.pc + imm_j;                       // jal
            7'b1100111: return (m_valid[bi] && m_tag[bi] == r.pc[31:8]) ? m_target[bi] : seq;
            default:    return seq;
        endcase
    endfunction

    // what the dut does at the edge that samples u
    task automatic model_update(input bp_update_t u);
        logic [9:0] pi;
        logic [5:0] bi;
        pi = u.pc[11:2] ^ m_ghr;  // history before the shift
        bi = u.pc[7:2];
        if (u.is_branch) begin
            if (u.taken && m_pht[pi] != 2'b11) begin
                m_pht[pi] = m_pht[pi] + 2'd1;
            end else if (!u.taken && m_pht[pi] != 2'b00) begin
                m_pht[pi] = m_pht[pi] - 2'd1;
            end
            m_ghr = {m_ghr[8:0], u.taken};
        end
        if (u.is_jump) begin
            m_valid[bi]  = 1'b1;
            m_tag[bi]    = u.pc[31:8];
            m_target[bi] = u.target;
        end
    endtask

    task automatic check_next_pc(input logic [2:0] beh, input logic [xlen-1:0] exp_pc);
        checks++;
        beh_checks[beh]++;
        assert (next_pc == exp_pc) else begin
            $display("[FAIL] pc 0x%08h next_pc expected 0x%08h actual 0x%08h",
                     req.pc, exp_pc, next_pc);
            fails++;
            beh_fails[beh]++;
        end
    endtask

    task automatic apply_reset();
        int cycles;
        rst_n  = 1'b0;
        req    = '0;
        req.ir = 32'h863;  // beq at pc 0 looks up counter 0 through the history
        upd    = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        model_reset();
        cycles = 0;
        // cleared history and counters give a not-taken branch
        while (next_pc !== 32'h4 && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (next_pc !== 32'h4) begin
            $display("predictor did not come out of reset within 20 cycles");
            fails++;
        end
    endtask

    task automatic add_row(input logic rst, input logic [31:0] pc, input logic [31:0] ir,
                           input logic [31:0] u_pc, input logic [31:0] u_tgt,
                           input logic [2:0] u_flags, input logic [31:0] exp_pc);
        row_t r;
        r.beh    = cur_beh;
        r.rst    = rst;
        r.req.pc = pc;
        r.req.ir = ir;
        r.upd    = {u_pc, u_tgt, u_flags};
        r.exp_pc = exp_pc;
        rows.push_back(r);
    endtask

    // beq +16 is 863, jalr is 8067, addi is 13
    task automatic build_table();
        cur_beh = 3'd1;
        add_row(1'b0, 32'h1000, 32'h863, 32'h0, 32'h0, 3'b000, 32'h1004);
        add_row(1'b0, 32'h2000, 32'h8067, 32'h0, 32'h0, 3'b000, 32'h2004);
        add_row(1'b0, 32'h3000, 32'h13, 32'h0, 32'h0, 3'b000, 32'h3004);
        cur_beh = 3'd2;
        add_row(1'b0, 32'h100000, 32'h7ffff06f, 32'h0, 32'h0, 3'b000, 32'h1ffffe);  // max fwd
        add_row(1'b0, 32'h100000, 32'h8000006f, 32'h0, 32'h0, 3'b000, 32'h0);       // max back
        add_row(1'b0, 32'h4000, 32'h80006f, 32'h0, 32'h0, 3'b000, 32'h4008);
        add_row(1'b0, 32'h4000, 32'hffdff06f, 32'h0, 32'h0, 3'b000, 32'h3ffc);
        cur_beh = 3'd3;
        add_row(1'b0, 32'h1040, 32'h863, 32'h1040, 32'h0, 3'b101, 32'h1044);  // idx 10 trained
        add_row(1'b0, 32'h1040, 32'h863, 32'h1040, 32'h0, 3'b101, 32'h1044);  // idx 11 trained
        add_row(1'b0, 32'h104c, 32'h863, 32'h0, 32'h0, 3'b000, 32'h105c);     // 13^3 hits 10
        add_row(1'b0, 32'h1048, 32'h863, 32'h0, 32'h0, 3'b000, 32'h1058);     // 12^3 hits 11
        add_row(1'b0, 32'h104c, 32'h863, 32'h104c, 32'h0, 3'b100, 32'h105c);
        add_row(1'b0, 32'h1058, 32'h863, 32'h0, 32'h0, 3'b000, 32'h105c);     // 16^6 is back at 1
        cur_beh = 3'd4;
        add_row(1'b0, 32'h2010, 32'h8067, 32'h2010, 32'h12340, 3'b010, 32'h2014);
        add_row(1'b0, 32'h2010, 32'h8067, 32'h0, 32'h0, 3'b000, 32'h12340);
        cur_beh = 3'd2;
        add_row(1'b0, 32'h2010, 32'h80006f, 32'h0, 32'h0, 3'b000, 32'h2018);  // jal ignores btb
        cur_beh = 3'd4;
        add_row(1'b0, 32'h3010, 32'h8067, 32'h0, 32'h0, 3'b000, 32'h3014);    // same idx with tag 30
        add_row(1'b0, 32'h3010, 32'h8067, 32'h3010, 32'h5550, 3'b010, 32'h3014);
        add_row(1'b0, 32'h3010, 32'h8067, 32'h0, 32'h0, 3'b000, 32'h5550);
        add_row(1'b0, 32'h2010, 32'h8067, 32'h0, 32'h0, 3'b000, 32'h2014);    // evicted
        cur_beh = 3'd5;
        add_row(1'b0, 32'h105c, 32'h863, 32'h105c, 32'h0, 3'b100, 32'h106c);  // sees old ctr
        add_row(1'b0, 32'h1074, 32'h863, 32'h0, 32'h0, 3'b000, 32'h1078);
        add_row(1'b0, 32'h2010, 32'h8067, 32'h2010, 32'h12340, 3'b010, 32'h2014);
        add_row(1'b0, 32'h2010, 32'h8067, 32'h0, 32'h0, 3'b000, 32'h12340);
        add_row(1'b0, 32'h1030, 32'h863, 32'h1030, 32'h0, 3'b101, 32'h1034);  // trains idx 0
        add_row(1'b0, 32'h1064, 32'h863, 32'h0, 32'h0, 3'b000, 32'h1074);     // 19^19 taken
        add_row(1'b1, 32'h1064, 32'h863, 32'h0, 32'h0, 3'b000, 32'h1068);     // after reset
        add_row(1'b0, 32'h1000, 32'h863, 32'h0, 32'h0, 3'b000, 32'h1004);
        add_row(1'b0, 32'h2010, 32'h8067, 32'h0, 32'h0, 3'b000, 32'h2014);
        add_row(1'b0, 32'h3000, 32'h13, 32'h0, 32'h0, 3'b000, 32'h3004);
    endtask

    task automatic run_row(input row_t r);
        if (r.rst) begin
            @(posedge clk);  // previous update lands first
            #1;
            apply_reset();
        end
        @(posedge clk);
        #1;
        req = r.req;
        upd = r.upd;
        #2;                   // still before the next edge
        check_next_pc(r.beh, r.exp_pc);
        model_update(r.upd);  // sampled at the coming edge
    endtask

    task automatic random_row();
        logic [31:0]     r_pc;
        logic [31:0]     r_ir;
        logic [31:0]     r_upd;
        logic [31:0]     r_tgt;
        logic [xlen-1:0] exp_pc;
        r_pc  = $random(seed);
        r_ir  = $random(seed);
        r_upd = $random(seed);
        r_tgt = $random(seed);
        @(posedge clk);
        #1;
        req.pc = 32'h2000 | (r_pc & 32'h1fc);  // 128 word pcs with two tags per btb index
        case (r_ir[1:0])
            2'd0:    req.ir = {r_ir[31:7], 7'b1100011};
            2'd1:    req.ir = {r_ir[31:7], 7'b1101111};
            2'd2:    req.ir = {r_ir[31:7], 7'b1100111};
            default: req.ir = {r_ir[31:7], 7'b0010011};
        endcase
        upd    = '0;
        upd.pc = r_upd[30] ? req.pc : (32'h2000 | (r_upd & 32'h1fc));
        case (r_upd[1:0])
            2'd0: begin
                upd.is_branch = 1'b1;
                upd.taken     = r_upd[31];
            end
            2'd1: begin
                upd.is_jump = 1'b1;
                upd.target  = {r_tgt[31:2], 2'b00};
            end
            default: upd.pc = '0;  // idle cycle
        endcase
        exp_pc = model_next_pc(req);
        #2;
        check_next_pc(3'd6, exp_pc);
        model_update(upd);
    endtask

    task automatic report_behavior(input int b);
        $display("behavior %0d %s: %0d checks, %0d failed", b, beh_name(b),
                 beh_checks[b], beh_fails[b]);
    endtask

    initial begin
        rst_n = 1'b0;
        req   = '0;
        upd   = '0;
        build_table();
        apply_reset();
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        for (int b = 1; b <= 5; b++) begin
            report_behavior(b);
        end
        for (int n = 0; n < 200; n++) begin
            random_row();
        end
        report_behavior(6);
        $display("checks %0d passed %0d failed %0d", checks, checks - fails, fails);
        if (fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // whole run takes a few hundred cycles
    initial begin
        #100000;
        $display("timeout, the run did not reach its end");
        $display("TB FAILED");
        $finish;
    end

endmodule
